/* uart_pkg.sv */
package uart_pkg;

    // byte width of the serial data path
    localparam int data_width = 8;

    // APB data bus width
    localparam int apb_width = 32;

    // baud ticks per serial bit
    localparam int oversample = 16;

    // ticks from the falling start edge to the middle of the start bit
    localparam int half_bit = 8;

    typedef enum logic [1:0] {
        apb_idle,
        apb_read,
        apb_write
    } apb_state_t;

    // word offsets, decoded from paddr[3:2]
    typedef enum logic [1:0] {
        reg_status   = 2'd0,
        reg_tx_data  = 2'd1,
        reg_rx_data  = 2'd2,
        reg_reserved = 2'd3
    } reg_addr_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

/* baud_tick_gen.sv */
`timescale 1ns/1ns

module baud_tick_gen import uart_pkg::*; #(
    parameter int clk_freq_hz = 100_000_000,
    parameter int baud_rate   = 9600
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // clocks between oversampling ticks
    localparam int div       = clk_freq_hz / (baud_rate * oversample);
    localparam int cnt_width = (div > 1) ? $clog2(div) : 1;

    logic [cnt_width-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_width'(div - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo import uart_pkg::*; #(
    parameter int fifo_addr_width = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [data_width-1:0] push_data,
    input  logic                  pop,
    output logic [data_width-1:0] pop_data,
    output logic                  full,
    output logic                  empty
);

    logic [data_width-1:0]      mem [0:2**fifo_addr_width-1];
    logic [fifo_addr_width-1:0] wptr, rptr;
    logic [fifo_addr_width-1:0] wptr_inc, rptr_inc;
    logic                       push_ok;
    logic                       pop_ok;

    // when full only the pop can act, when empty only the push
    assign push_ok  = push && !full;
    assign pop_ok   = pop && !empty;
    assign wptr_inc = wptr + 1'b1;
    assign rptr_inc = rptr + 1'b1;
    assign pop_data = mem[rptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (push_ok) begin
                wptr <= wptr_inc;
            end
            if (pop_ok) begin
                rptr <= rptr_inc;
            end
            // a push and a pop together leave the fill level as it is
            if (push_ok && !pop_ok) begin
                empty <= 1'b0;
                full  <= (wptr_inc == rptr);
            end else if (pop_ok && !push_ok) begin
                full  <= 1'b0;
                empty <= (rptr_inc == wptr);
            end
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else $error("fifo reports full and empty together");

    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        push && full |=> $stable(wptr))
        else $error("write pointer moved on a push while full");

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  byte_valid,
    input  logic [data_width-1:0] byte_in,
    output logic                  byte_take,
    output logic                  busy,
    output logic                  tx
);

    localparam int tick_w = $clog2(oversample);
    localparam int bit_w  = $clog2(data_width);
    localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
    localparam logic [bit_w-1:0]  bit_last  = bit_w'(data_width - 1);

    tx_state_t             state, state_next;
    logic [tick_w-1:0]     tick_cnt, tick_cnt_next;
    logic [bit_w-1:0]      bit_cnt, bit_cnt_next;
    logic [data_width-1:0] data_buf, data_buf_next;
    logic                  tx_next;
    logic                  take_next;

    assign busy = (state != tx_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= tx_idle;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            tx        <= 1'b1;
            byte_take <= 1'b0;
        end else begin
            state     <= state_next;
            tick_cnt  <= tick_cnt_next;
            bit_cnt   <= bit_cnt_next;
            tx        <= tx_next;
            byte_take <= take_next;
        end
    end

    always_ff @(posedge clk) begin
        data_buf <= data_buf_next;
    end

    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        data_buf_next = data_buf;
        tx_next       = 1'b1;
        take_next     = 1'b0;
        case (state)
            tx_idle: begin
                if (byte_valid) begin
                    state_next    = tx_start;
                    tick_cnt_next = '0;
                    take_next     = 1'b1;
                end
            end
            tx_start: begin
                tx_next = 1'b0;
                // the fifo pops on this same edge, so the head is still ours
                if (byte_take) begin
                    data_buf_next = byte_in;
                end
                if (tick) begin
                    if (tick_cnt == tick_last) begin
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                        state_next    = tx_data;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            tx_data: begin
                tx_next = data_buf[0];
                if (tick) begin
                    if (tick_cnt == tick_last) begin
                        tick_cnt_next = '0;
                        if (bit_cnt == bit_last) begin
                            state_next = tx_stop;
                        end else begin
                            bit_cnt_next  = bit_cnt + 1'b1;
                            data_buf_next = data_buf >> 1;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            tx_stop: begin
                if (tick) begin
                    if (tick_cnt == tick_last) begin
                        tick_cnt_next = '0;
                        state_next    = tx_idle;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: begin
                state_next = tx_idle;
            end
        endcase
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst) state == tx_idle |-> tx)
        else $error("tx line low while transmitter idle");

endmodule

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  rx,
    output logic [data_width-1:0] byte_out,
    output logic                  byte_done
);

    localparam int tick_w = $clog2(oversample);
    localparam int bit_w  = $clog2(data_width);
    localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
    localparam logic [tick_w-1:0] half_last = tick_w'(half_bit - 1);
    localparam logic [bit_w-1:0]  bit_last  = bit_w'(data_width - 1);

    rx_state_t             state, state_next;
    logic [1:0]            rx_sync;
    logic                  rx_s;
    logic [tick_w-1:0]     tick_cnt, tick_cnt_next;
    logic [bit_w-1:0]      bit_cnt, bit_cnt_next;
    logic [data_width-1:0] data_buf, data_buf_next;
    logic                  done_next;

    assign rx_s     = rx_sync[1];
    assign byte_out = data_buf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync   <= 2'b11;
            state     <= rx_idle;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            rx_sync   <= {rx_sync[0], rx};
            state     <= state_next;
            tick_cnt  <= tick_cnt_next;
            bit_cnt   <= bit_cnt_next;
            byte_done <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        data_buf <= data_buf_next;
    end

    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        data_buf_next = data_buf;
        done_next     = 1'b0;
        case (state)
            rx_idle: begin
                if (!rx_s) begin
                    state_next    = rx_start;
                    tick_cnt_next = '0;
                end
            end
            rx_start: begin
                if (tick) begin
                    if (tick_cnt == half_last) begin
                        // a line that is high again at mid start bit was a glitch
                        if (rx_s) begin
                            state_next = rx_idle;
                        end else begin
                            state_next    = rx_data;
                            tick_cnt_next = '0;
                            bit_cnt_next  = '0;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            rx_data: begin
                if (tick) begin
                    if (tick_cnt == tick_last) begin
                        data_buf_next = {rx_s, data_buf[data_width-1:1]};
                        tick_cnt_next = '0;
                        if (bit_cnt == bit_last) begin
                            state_next = rx_stop;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            rx_stop: begin
                if (tick) begin
                    if (tick_cnt == tick_last) begin
                        done_next  = 1'b1;
                        state_next = rx_idle;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: begin
                state_next = rx_idle;
            end
        endcase
    end

    a_done_single: assert property (@(posedge clk) disable iff (rst) byte_done |=> !byte_done)
        else $error("byte_done held high for two cycles");

endmodule

/* apb_uart_regs.sv */
`timescale 1ns/1ns

module apb_uart_regs import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [3:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_width-1:0]  pwdata,
    output logic [apb_width-1:0]  prdata,
    output logic                  pready,
    input  logic [3:0]            status,
    output logic                  tx_push,
    output logic [data_width-1:0] tx_push_data,
    output logic                  rx_pop,
    input  logic [data_width-1:0] rx_data
);

    apb_state_t            state, state_next;
    reg_addr_t             addr;
    logic [data_width-1:0] tx_data_reg, tx_data_next;
    logic [apb_width-1:0]  prdata_next;
    logic                  pready_next;
    logic                  tx_push_next;
    logic                  rx_pop_next;

    assign addr         = reg_addr_t'(paddr[3:2]);
    assign tx_push_data = tx_data_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= apb_idle;
            tx_data_reg <= '0;
            prdata      <= '0;
            pready      <= 1'b0;
            tx_push     <= 1'b0;
            rx_pop      <= 1'b0;
        end else begin
            state       <= state_next;
            tx_data_reg <= tx_data_next;
            prdata      <= prdata_next;
            pready      <= pready_next;
            tx_push     <= tx_push_next;
            rx_pop      <= rx_pop_next;
        end
    end

    // strobes and pready are registered so they all land in the access phase cycle
    always_comb begin
        state_next   = state;
        tx_data_next = tx_data_reg;
        prdata_next  = prdata;
        pready_next  = 1'b0;
        tx_push_next = 1'b0;
        rx_pop_next  = 1'b0;
        case (state)
            apb_idle: begin
                if (psel && penable) begin
                    pready_next = 1'b1;
                    if (pwrite) begin
                        state_next = apb_write;
                        if (addr == reg_tx_data) begin
                            tx_data_next = pwdata[data_width-1:0];
                            tx_push_next = 1'b1;
                        end
                    end else begin
                        state_next = apb_read;
                        case (addr)
                            reg_status:   prdata_next = apb_width'(status);
                            reg_tx_data:  prdata_next = apb_width'(tx_data_reg);
                            reg_rx_data: begin
                                // head is captured now, the pop follows with pready
                                prdata_next = apb_width'(rx_data);
                                rx_pop_next = 1'b1;
                            end
                            reg_reserved: prdata_next = '0;
                            default:      prdata_next = '0;
                        endcase
                    end
                end
            end
            apb_read, apb_write: begin
                state_next = apb_idle;
            end
            default: begin
                state_next = apb_idle;
            end
        endcase
    end

    // every access gets exactly one ready cycle
    a_pready_single: assert property (@(posedge clk) disable iff (rst) pready |=> !pready)
        else $error("pready held high for two cycles");

endmodule

/* apb_uart.sv */
`timescale 1ns/1ns

module apb_uart import uart_pkg::*; #(
    parameter int clk_freq_hz     = 100_000_000,
    parameter int baud_rate       = 9600,
    parameter int fifo_addr_width = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [3:0]           paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [apb_width-1:0] pwdata,
    output logic [apb_width-1:0] prdata,
    output logic                 pready,
    input  logic                 rx,
    output logic                 tx
);

    logic [3:0]            status;
    logic                  tick;
    logic                  tx_push, rx_pop;
    logic [data_width-1:0] tx_push_data, rx_head;
    logic [data_width-1:0] tx_head, rx_byte;
    logic                  tx_full, tx_empty, rx_full, rx_empty;
    logic                  byte_take, byte_done;

    assign status = {rx_full, tx_empty, tx_full, rx_empty};

    apb_uart_regs u_regs (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .status(status), .tx_push(tx_push), .tx_push_data(tx_push_data),
        .rx_pop(rx_pop), .rx_data(rx_head)
    );

    baud_tick_gen #(.clk_freq_hz(clk_freq_hz), .baud_rate(baud_rate)) u_tick (
        .clk(clk), .rst(rst), .tick(tick)
    );

    byte_fifo #(.fifo_addr_width(fifo_addr_width)) u_tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_push_data),
        .pop(byte_take), .pop_data(tx_head), .full(tx_full), .empty(tx_empty)
    );

    byte_fifo #(.fifo_addr_width(fifo_addr_width)) u_rx_fifo (
        .clk(clk), .rst(rst), .push(byte_done), .push_data(rx_byte),
        .pop(rx_pop), .pop_data(rx_head), .full(rx_full), .empty(rx_empty)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .tick(tick), .byte_valid(!tx_empty), .byte_in(tx_head),
        .byte_take(byte_take), .busy(), .tx(tx)
    );

    uart_rx u_uart_rx (
        .clk(clk), .rst(rst), .tick(tick), .rx(rx),
        .byte_out(rx_byte), .byte_done(byte_done)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb_apb_uart.sv */
`timescale 1ns/1ns

module tb_apb_uart import uart_pkg::*; ();

    // 125 MHz and 1953125 baud give a tick every 4 clocks, 64 clocks per bit
    localparam int clk_freq_hz   = 125_000_000;
    localparam int baud_rate     = 1_953_125;
    localparam int fifo_aw       = 3;
    localparam int bit_clks      = 64;
    localparam int apb_timeout   = 50;
    localparam int frame_timeout = 2000;
    localparam int status_polls  = 20;

    logic        clk;
    logic        rst;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        rx;
    logic        tx;
    int          errors;
    int          checks;

    tb_clk_gen #(.half_period(4), .reset_cycles(5)) u_clk_gen (.clk(clk), .rst(rst));

    apb_uart #(
        .clk_freq_hz(clk_freq_hz),
        .baud_rate(baud_rate),
        .fifo_addr_width(fifo_aw)
    ) u_apb_uart (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .rx(rx), .tx(tx)
    );

    function automatic logic [3:0] addr_of(reg_addr_t r);
        return {r, 2'b00};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // setup phase, then access phase held until pready is seen at a falling edge
    task automatic apb_access(input logic [3:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        rdata = '0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < apb_timeout) begin
            @(negedge clk);
            n++;
        end
        if (pready) begin
            rdata = prdata;
            // pready belongs to the cycle right after the access phase is seen
            expect_eq("pready (wait cycles)", n, 1);
        end else begin
            errors++;
            $display("APB access to address 0x%h got no pready in time", addr);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(negedge clk);
        expect_eq("pready (after ready cycle)", {31'b0, pready}, 32'h0);
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        apb_access(addr, 1'b1, data, ignored);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        apb_access(addr, 1'b0, 32'h0, data);
    endtask

    // one 8N1 frame on rx, each bit held for a full bit time
    task automatic send_frame(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[0];
            frame = frame >> 1;
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    // finds the start edge on tx, then samples every bit at its middle
    task automatic receive_frame(output logic [7:0] b);
        int n;
        b = '0;
        n = 0;
        @(negedge clk);
        while (tx && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (tx) begin
            errors++;
            $display("no start bit appeared on tx in time");
        end else begin
            repeat (bit_clks / 2) @(negedge clk);
            expect_eq("tx (start bit)", {31'b0, tx}, 32'h0);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                b = {tx, b[7:1]};
            end
            repeat (bit_clks) @(negedge clk);
            expect_eq("tx (stop bit)", {31'b0, tx}, 32'h1);
        end
    endtask

    task automatic wait_rx_ready();
        logic [31:0] d;
        int n;
        n = 0;
        apb_read(addr_of(reg_status), d);
        while (d[0] && n < status_polls) begin
            apb_read(addr_of(reg_status), d);
            n++;
        end
        if (d[0]) begin
            errors++;
            $display("receive FIFO stayed empty after a frame on rx");
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge clk);
        while (rst && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            errors++;
            $display("reset was never released");
        end
        @(posedge clk);
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        int lows;
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status)", d, 32'h5);
        apb_read(addr_of(reg_reserved), d);
        expect_eq("prdata (reserved)", d, 32'h0);
        apb_write(addr_of(reg_reserved), {rand_byte(), rand_byte(), rand_byte(), rand_byte()});
        apb_read(addr_of(reg_reserved), d);
        expect_eq("prdata (reserved)", d, 32'h0);
        apb_read(addr_of(reg_tx_data), d);
        expect_eq("prdata (tx data)", d, 32'h0);
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status)", d, 32'h5);
        lows = 0;
        for (int i = 0; i < 2 * bit_clks; i++) begin
            @(negedge clk);
            if (!tx) lows++;
        end
        expect_eq("tx (low samples while idle)", lows, 0);
    endtask

    task automatic test_single_tx();
        logic [7:0]  b;
        logic [7:0]  got;
        logic [31:0] d;
        b = rand_byte();
        fork
            apb_write(addr_of(reg_tx_data), {24'h0, b});
            receive_frame(got);
        join
        expect_eq("tx (frame data)", {24'h0, got}, {24'h0, b});
        apb_read(addr_of(reg_tx_data), d);
        expect_eq("prdata (tx data)", d, {24'h0, b});
    endtask

    task automatic test_burst_tx();
        logic [7:0]  sent[$];
        logic [7:0]  got[$];
        logic [7:0]  b;
        logic [31:0] d;
        for (int i = 0; i < 9; i++) begin
            sent.push_back(rand_byte());
        end
        fork
            begin
                for (int i = 0; i < 9; i++) begin
                    apb_write(addr_of(reg_tx_data), {24'h0, sent[i]});
                end
                apb_read(addr_of(reg_status), d);
                expect_eq("prdata (status tx_full)", {31'b0, d[1]}, 32'h1);
            end
            begin
                for (int i = 0; i < 9; i++) begin
                    receive_frame(b);
                    got.push_back(b);
                end
            end
        join
        while (sent.size() > 0) begin
            expect_eq("tx (burst frame)", {24'h0, got.pop_front()}, {24'h0, sent.pop_front()});
        end
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status)", d, 32'h5);
    endtask

    task automatic test_receive();
        logic [7:0]  b;
        logic [31:0] d;
        for (int i = 0; i < 3; i++) begin
            b = rand_byte();
            send_frame(b);
            wait_rx_ready();
            apb_read(addr_of(reg_rx_data), d);
            expect_eq("prdata (rx data)", d, {24'h0, b});
        end
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status)", d, 32'h5);
    endtask

    task automatic test_rx_overflow();
        logic [7:0]  sent[$];
        logic [31:0] d;
        for (int i = 0; i < 9; i++) begin
            sent.push_back(rand_byte());
            send_frame(sent[i]);
        end
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status rx_full)", {31'b0, d[3]}, 32'h1);
        // only the first eight fit, the ninth byte is dropped
        for (int i = 0; i < 8; i++) begin
            apb_read(addr_of(reg_rx_data), d);
            expect_eq("prdata (rx data)", d, {24'h0, sent.pop_front()});
        end
        apb_read(addr_of(reg_status), d);
        expect_eq("prdata (status rx_empty)", {31'b0, d[0]}, 32'h1);
    endtask

    initial begin
        void'($urandom(32'ha135_470d));
        errors = 0;
        checks = 0;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        rx      <= 1'b1;
        wait_reset_release();
        test_reset_state();
        test_single_tx();
        test_burst_tx();
        test_receive();
        test_rx_overflow();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
uart_pkg.sv
baud_tick_gen.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
apb_uart_regs.sv
apb_uart.sv
tb_clk_gen.sv
tb_apb_uart.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_apb_uart
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
